//--- verilog/ll_pkg.sv
// Link-layer definitions for the die-to-die receive path
// Flit layout inside the PHY word, lane geometry, credit pool
// and the online sequencing states
package ll_pkg;

  ////////////////////////////////////////////////////////////
  // Flit and PHY word layout

  // Flit is {tlast, tkeep, tdata} from the top bit down
  localparam int FLIT_WIDTH = 73;
  localparam int PHY_WIDTH  = 80;

  // Bit positions inside rx_phy / tx_phy
  localparam int PUSH_BIT   = 73;
  localparam int STROBE_BIT = 79;
  // Credit return, tx_phy only
  localparam int CREDIT_BIT = 0;

  ////////////////////////////////////////////////////////////
  // Lane banks and credit pool

  localparam int NUM_LANES  = 2;
  localparam int LANE_DEPTH = 16;

  // Far side starts with one credit per flit slot
  localparam int TOTAL_CREDIT = NUM_LANES * LANE_DEPTH;

  // At least one bit even for a single lane
  localparam int LANE_SEL_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  ////////////////////////////////////////////////////////////
  // Auto-sync FSM

  typedef enum logic [1:0] {
    SYNC_OFF     = 2'd0,
    SYNC_TX_WAIT = 2'd1,
    SYNC_RX_WAIT = 2'd2,
    SYNC_ONLINE  = 2'd3
  } sync_state_e;

endpackage

//--- verilog/axi_st_pkg.sv
// User-side AXI-Stream definitions
// Data and keep widths of the 64-bit master port
// and the states of the lane merge FSM
package axi_st_pkg;

  ////////////////////////////////////////////////////////////
  // Stream widths

  localparam int DATA_WIDTH = 64;
  // One keep bit per byte
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;

  ////////////////////////////////////////////////////////////
  // Merge FSM

  // Idle means output register empty
  typedef enum logic {
    MERGE_IDLE = 1'b0,
    MERGE_HOLD = 1'b1
  } merge_state_e;

endpackage

//--- verilog/ll_auto_sync.sv
// Online sequencing for the link layer
// Delays tx_online by delay_x cycles, then waits delay_y cycles
// of rx_online before declaring the receive side online.
// Emits an alignment strobe for delay_z cycles once tx is up.
module ll_auto_sync (
  input  logic        clk_wr,
  input  logic        reset,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        tx_stb
);
  import ll_pkg::*;

  sync_state_e state;
  // Shared by the tx and rx wait phases
  logic [15:0] count;
  // Strobe countdown
  logic [15:0] stb_count;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state     <= SYNC_OFF;
      count     <= '0;
      stb_count <= '0;
    end else begin
      if (stb_count != 16'd0) begin
        stb_count <= stb_count - 16'd1;
      end
      case (state)
        SYNC_OFF: begin
          stb_count <= '0;
          // Edge that sees tx_online counts as the first cycle
          if (tx_online) begin
            state <= SYNC_TX_WAIT;
            count <= 16'd1;
          end
        end
        SYNC_TX_WAIT: begin
          if (!tx_online) begin
            state <= SYNC_OFF;
          end else if (count >= delay_x_value) begin
            state     <= SYNC_RX_WAIT;
            count     <= '0;
            stb_count <= delay_z_value;
          end else begin
            count <= count + 16'd1;
          end
        end
        SYNC_RX_WAIT: begin
          if (!tx_online) begin
            state <= SYNC_OFF;
          end else if (!rx_online) begin
            // Far side not up yet, restart the count
            count <= '0;
          end else if (count >= delay_y_value) begin
            state <= SYNC_ONLINE;
          end else begin
            count <= count + 16'd1;
          end
        end
        SYNC_ONLINE: begin
          if (!tx_online || !rx_online) begin
            state <= SYNC_OFF;
          end
        end
        default: state <= SYNC_OFF;
      endcase
    end
  end

  // Online flags decoded from state
  assign tx_online_delay = (state == SYNC_RX_WAIT) || (state == SYNC_ONLINE);
  assign rx_online_delay = (state == SYNC_ONLINE);
  assign tx_stb          = tx_online_delay && (stb_count != 16'd0);

endmodule

//--- verilog/phy_rx_deframer.sv
// PHY word deframer for the receive link
// Registers rx_phy, accepts pushes only while online,
// returns credits and the strobe through tx_phy
// and keeps the debug counters
module phy_rx_deframer (
  input  logic                          clk_wr,
  input  logic                          reset,
  input  logic [ll_pkg::PHY_WIDTH-1:0]  rx_phy,
  input  logic                          rx_online_delay,
  input  logic                          tx_online_delay,
  input  logic                          tx_stb,
  input  logic                          credit_pulse,
  input  logic [ll_pkg::NUM_LANES-1:0]  lane_overflow,
  output logic [ll_pkg::FLIT_WIDTH-1:0] flit_data,
  output logic                          flit_push,
  output logic [ll_pkg::PHY_WIDTH-1:0]  tx_phy,
  output logic [31:0]                   rx_st_debug_status
);
  import ll_pkg::*;

  logic        push_in;
  logic        push_ok;
  logic        credit_q;
  logic [15:0] accept_cnt;
  logic [7:0]  drop_cnt;

  assign push_in = rx_phy[PUSH_BIT];
  // Pushes before online are dropped
  assign push_ok = push_in && rx_online_delay;

  // Payload register
  always_ff @(posedge clk_wr) begin
    flit_data <= rx_phy[FLIT_WIDTH-1:0];
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      flit_push  <= 1'b0;
      credit_q   <= 1'b0;
      accept_cnt <= '0;
      drop_cnt   <= '0;
    end else begin
      flit_push <= push_ok;
      credit_q  <= credit_pulse;
      // Accepted count wraps
      if (push_ok) begin
        accept_cnt <= accept_cnt + 16'd1;
      end
      // Dropped count saturates
      if (push_in && !rx_online_delay && (drop_cnt != 8'hff)) begin
        drop_cnt <= drop_cnt + 8'd1;
      end
    end
  end

  // Outgoing word, silent until tx side is online
  always_comb begin
    tx_phy = '0;
    if (tx_online_delay) begin
      tx_phy[STROBE_BIT] = tx_stb;
      tx_phy[CREDIT_BIT] = credit_q;
    end
  end

  assign rx_st_debug_status = {5'd0, tx_online_delay, rx_online_delay,
                               |lane_overflow, drop_cnt, accept_cnt};

endmodule

//--- verilog/lane_steer.sv
// Round-robin flit distributor
// Each accepted flit goes to the next lane bank in turn,
// wrapping after the last lane
module lane_steer (
  input  logic                          clk_wr,
  input  logic                          reset,
  input  logic                          flit_push,
  input  logic [ll_pkg::FLIT_WIDTH-1:0] flit_data,
  output logic [ll_pkg::NUM_LANES-1:0]  lane_wr_en,
  output logic [ll_pkg::FLIT_WIDTH-1:0] lane_wr_data
);
  import ll_pkg::*;

  logic [LANE_SEL_WIDTH-1:0] wr_ptr;

  // Write pointer, advances once per push
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (flit_push) begin
      if (wr_ptr == LANE_SEL_WIDTH'(NUM_LANES - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // One-hot enable for the selected lane
  always_comb begin
    lane_wr_en = '0;
    if (flit_push) begin
      lane_wr_en[wr_ptr] = 1'b1;
    end
  end

  // Data fans out to all lanes, enable picks one
  assign lane_wr_data = flit_data;

endmodule

//--- verilog/ll_receive.sv
// Receive FIFO bank for one lane
// Circular buffer with valid/ready read side.
// A write into a full bank is discarded and
// sets the sticky overflow flag.
module ll_receive #(
  parameter int DEPTH = ll_pkg::LANE_DEPTH
) (
  input  logic                          clk_wr,
  input  logic                          reset,
  input  logic                          wr_en,
  input  logic [ll_pkg::FLIT_WIDTH-1:0] wr_data,
  input  logic                          rd_ready,
  output logic                          rd_valid,
  output logic [ll_pkg::FLIT_WIDTH-1:0] rd_data,
  output logic                          overflow
);
  import ll_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // Count needs one extra bit to hold DEPTH
  localparam int CW = AW + 1;

  logic [FLIT_WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  full;
  logic                  do_wr;
  logic                  do_rd;

  // Pointer increment with wrap for any depth
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full     = (count == CW'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_data  = mem[rd_ptr];
  assign do_wr    = wr_en && !full;
  assign do_rd    = rd_valid && rd_ready;

  // Storage
  always_ff @(posedge clk_wr) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy and overflow

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous read and write leaves count alone
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      // Sticky once set
      if (wr_en && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/stream_merge.sv
// Lane merge onto the user AXI-Stream master port
// Drains the banks in the same round-robin order as they
// were filled, registers the output beat, and pulses a
// credit for every user handshake
module stream_merge (
  input  logic                                               clk_wr,
  input  logic                                               reset,
  input  logic [ll_pkg::NUM_LANES-1:0]                       lane_rd_valid,
  input  logic [ll_pkg::NUM_LANES-1:0][ll_pkg::FLIT_WIDTH-1:0] lane_rd_data,
  input  logic                                               user_tready,
  output logic [ll_pkg::NUM_LANES-1:0]                       lane_rd_ready,
  output logic [axi_st_pkg::DATA_WIDTH-1:0]                  user_tdata,
  output logic [axi_st_pkg::KEEP_WIDTH-1:0]                  user_tkeep,
  output logic                                               user_tlast,
  output logic                                               user_tvalid,
  output logic                                               credit_pulse
);
  import ll_pkg::*;
  import axi_st_pkg::*;

  merge_state_e              state;
  logic [LANE_SEL_WIDTH-1:0] rd_ptr;
  logic [FLIT_WIDTH-1:0]     out_flit;
  logic                      load_en;
  logic                      take;

  // Output register free or emptied this cycle
  assign load_en = (state == MERGE_IDLE) || user_tready;
  assign take    = lane_rd_valid[rd_ptr] && load_en;

  // Ready only on the lane whose turn it is
  always_comb begin
    lane_rd_ready = '0;
    if (load_en) begin
      lane_rd_ready[rd_ptr] = 1'b1;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state  <= MERGE_IDLE;
      rd_ptr <= '0;
    end else if (take) begin
      state <= MERGE_HOLD;
      if (rd_ptr == LANE_SEL_WIDTH'(NUM_LANES - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end else if (user_tready) begin
      // Beat taken, nothing behind it
      state <= MERGE_IDLE;
    end
  end

  // Output beat, holds while stalled
  always_ff @(posedge clk_wr) begin
    if (take) begin
      out_flit <= lane_rd_data[rd_ptr];
    end
  end

  assign user_tvalid  = (state == MERGE_HOLD);
  assign user_tdata   = out_flit[DATA_WIDTH-1:0];
  assign user_tkeep   = out_flit[DATA_WIDTH +: KEEP_WIDTH];
  assign user_tlast   = out_flit[FLIT_WIDTH-1];
  assign credit_pulse = user_tvalid && user_tready;

endmodule

//--- verilog/axi_st_d64_slave_top.sv
// Receive side of the die-to-die AXI-Stream link, 64-bit data
// Auto-sync, PHY deframer, round-robin lane steering,
// per-lane receive banks and ordered merge onto the user port
module axi_st_d64_slave_top (
  input  logic                              clk_wr,
  input  logic                              reset,

  // Link control
  input  logic                              tx_online,
  input  logic                              rx_online,
  input  logic [15:0]                       delay_x_value,
  input  logic [15:0]                       delay_y_value,
  input  logic [15:0]                       delay_z_value,

  // PHY words
  input  logic [ll_pkg::PHY_WIDTH-1:0]      rx_phy,
  output logic [ll_pkg::PHY_WIDTH-1:0]      tx_phy,

  // User stream
  output logic [axi_st_pkg::DATA_WIDTH-1:0] user_tdata,
  output logic [axi_st_pkg::KEEP_WIDTH-1:0] user_tkeep,
  output logic                              user_tlast,
  output logic                              user_tvalid,
  input  logic                              user_tready,

  // Debug
  output logic [31:0]                       rx_st_debug_status
);
  import ll_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect

  logic                                 tx_online_delay;
  logic                                 rx_online_delay;
  logic                                 tx_stb;
  logic [FLIT_WIDTH-1:0]                flit_data;
  logic                                 flit_push;
  logic [NUM_LANES-1:0]                 lane_wr_en;
  logic [FLIT_WIDTH-1:0]                lane_wr_data;
  logic [NUM_LANES-1:0]                 lane_rd_valid;
  logic [NUM_LANES-1:0]                 lane_rd_ready;
  logic [NUM_LANES-1:0][FLIT_WIDTH-1:0] lane_rd_data;
  logic [NUM_LANES-1:0]                 lane_overflow;
  logic                                 credit_pulse;

  ////////////////////////////////////////////////////////////
  // Sync and PHY side

  ll_auto_sync u_auto_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb          (tx_stb)
  );

  phy_rx_deframer u_deframer (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .rx_phy             (rx_phy),
    .rx_online_delay    (rx_online_delay),
    .tx_online_delay    (tx_online_delay),
    .tx_stb             (tx_stb),
    .credit_pulse       (credit_pulse),
    .lane_overflow      (lane_overflow),
    .flit_data          (flit_data),
    .flit_push          (flit_push),
    .tx_phy             (tx_phy),
    .rx_st_debug_status (rx_st_debug_status)
  );

  lane_steer u_steer (
    .clk_wr       (clk_wr),
    .reset        (reset),
    .flit_push    (flit_push),
    .flit_data    (flit_data),
    .lane_wr_en   (lane_wr_en),
    .lane_wr_data (lane_wr_data)
  );

  ////////////////////////////////////////////////////////////
  // Lane banks

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    ll_receive #(.DEPTH(LANE_DEPTH)) u_receive (
      .clk_wr   (clk_wr),
      .reset    (reset),
      .wr_en    (lane_wr_en[i]),
      .wr_data  (lane_wr_data),
      .rd_ready (lane_rd_ready[i]),
      .rd_valid (lane_rd_valid[i]),
      .rd_data  (lane_rd_data[i]),
      .overflow (lane_overflow[i])
    );
  end

  // Ordered drain onto the user port
  stream_merge u_merge (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .lane_rd_valid (lane_rd_valid),
    .lane_rd_data  (lane_rd_data),
    .user_tready   (user_tready),
    .lane_rd_ready (lane_rd_ready),
    .user_tdata    (user_tdata),
    .user_tkeep    (user_tkeep),
    .user_tlast    (user_tlast),
    .user_tvalid   (user_tvalid),
    .credit_pulse  (credit_pulse)
  );

endmodule

//--- bench/axi_st_slave_assertions.sv
// Bound protocol checks for the receive link
// One checker serves both the user port of the merge and
// the read side of each lane bank
module axi_st_slave_assertions (
  input logic                          clk_wr,
  input logic                          reset,
  input logic                          valid,
  input logic                          ready,
  input logic [ll_pkg::FLIT_WIDTH-1:0] data,
  input logic [ll_pkg::NUM_LANES-1:0]  sel,
  input logic                          overflow
);

  // Stalled beat stays put
  stall_hold: assert property (@(posedge clk_wr) disable iff (reset)
    valid && !ready |=> valid && $stable(data))
    else $error("beat changed or dropped while stalled");

  // At most one lane granted
  grant_onehot: assert property (@(posedge clk_wr) disable iff (reset) $onehot0(sel))
    else $error("more than one lane ready at once");

  // Credit keeps every bank below full
  no_overflow: assert property (@(posedge clk_wr) disable iff (reset) !overflow)
    else $error("lane bank overflow");

endmodule

bind stream_merge axi_st_slave_assertions u_merge_checks (
  .clk_wr   (clk_wr),
  .reset    (reset),
  .valid    (user_tvalid),
  .ready    (user_tready),
  .data     ({user_tlast, user_tkeep, user_tdata}),
  .sel      (lane_rd_ready),
  .overflow (1'b0)
);

bind ll_receive axi_st_slave_assertions u_lane_checks (
  .clk_wr   (clk_wr),
  .reset    (reset),
  .valid    (rd_valid),
  .ready    (rd_ready),
  .data     (rd_data),
  .sel      (ll_pkg::NUM_LANES'(rd_ready)),
  .overflow (overflow)
);

//--- bench/tb_axi_st_slave.sv
// Testbench for the 64-bit AXI-Stream receive link
// Plays the far side of the die-to-die link with a credit counter,
// drives random flits and back-pressure, and checks ordering,
// credit return, online sequencing and the debug counters
module tb_axi_st_slave;
  import ll_pkg::*;
  import axi_st_pkg::*;

  localparam int STREAM_BEATS   = 300;
  localparam int SYNC_CYCLES    = 5 + 7 + 3;
  localparam int TIMEOUT_CYCLES = (STREAM_BEATS + TOTAL_CREDIT) * 4 + SYNC_CYCLES + 1000;
  // user_tready modes
  localparam int READY_LOW    = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_RANDOM = 2;

  logic                  clk_wr;
  logic                  reset;
  logic                  tx_online;
  logic                  rx_online;
  logic [15:0]           delay_x_value;
  logic [15:0]           delay_y_value;
  logic [15:0]           delay_z_value;
  logic [PHY_WIDTH-1:0]  rx_phy;
  logic [PHY_WIDTH-1:0]  tx_phy;
  logic [DATA_WIDTH-1:0] user_tdata;
  logic [KEEP_WIDTH-1:0] user_tkeep;
  logic                  user_tlast;
  logic                  user_tvalid;
  logic                  user_tready;
  logic [31:0]           rx_st_debug_status;

  ////////////////////////////////////////////////////////////
  // Scoreboard state

  // Fields of every accepted push, in push order
  logic [DATA_WIDTH-1:0] data_q[$];
  logic [KEEP_WIDTH-1:0] keep_q[$];
  logic                  last_q[$];
  logic [31:0]           lfsr;
  string                 test_name;
  int                    tready_mode;
  int                    accepted;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    test_errors0;
  // Owned by the monitor
  int                    beats_seen;
  int                    credits_seen;
  int                    beat_errors;
  logic                  stb_seen;

  axi_st_d64_slave_top u_dut (
    .clk_wr             (clk_wr),
    .reset              (reset),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value),
    .rx_phy             (rx_phy),
    .tx_phy             (tx_phy),
    .user_tdata         (user_tdata),
    .user_tkeep         (user_tkeep),
    .user_tlast         (user_tlast),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .rx_st_debug_status (rx_st_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // Beat idx on the user port, built as {tlast, tkeep, tdata}
  function automatic logic [FLIT_WIDTH-1:0] expected_flit(input int idx);
    return {last_q[idx], keep_q[idx], data_q[idx]};
  endfunction

  // Far side holds what it started with, minus pushes, plus returns
  function automatic int far_credit();
    return TOTAL_CREDIT - accepted + credits_seen;
  endfunction

  function automatic int total_errors();
    return errors + beat_errors;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks

  task automatic check_flit(input string what, input logic [FLIT_WIDTH-1:0] exp,
                            input logic [FLIT_WIDTH-1:0] act);
    if (act !== exp) begin
      beat_errors++;
      $display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // Compare every handshake against the pushed flits, collect credits
  always @(negedge clk_wr) begin
    if (!reset) begin
      if (user_tvalid && user_tready) begin
        if (beats_seen < data_q.size()) begin
          check_flit("beat", expected_flit(beats_seen), {user_tlast, user_tkeep, user_tdata});
        end else begin
          beat_errors++;
          $display("%s: a beat came out with no flit pushed for it", test_name);
        end
        beats_seen++;
      end
      if (tx_phy[CREDIT_BIT]) begin
        credits_seen++;
      end
      if (tx_phy[STROBE_BIT]) begin
        stb_seen = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Drive helpers, one cycle per call

  task automatic drive_cycle(input logic push, input logic [FLIT_WIDTH-1:0] flit);
    @(posedge clk_wr);
    #2;
    rx_phy                 = '0;
    rx_phy[FLIT_WIDTH-1:0] = flit;
    rx_phy[PUSH_BIT]       = push;
    case (tready_mode)
      READY_LOW:  user_tready = 1'b0;
      READY_HIGH: user_tready = 1'b1;
      // Low about 30% of cycles
      default:    user_tready = (rand_bits(8) >= 64'd77);
    endcase
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0);
  endtask

  // Wait for credit, then push one random beat
  task automatic push_beat(input logic last);
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    while (far_credit() == 0) begin
      drive_cycle(1'b0, '0);
    end
    data = rand_bits(DATA_WIDTH);
    keep = KEEP_WIDTH'(rand_bits(KEEP_WIDTH));
    data_q.push_back(data);
    keep_q.push_back(keep);
    last_q.push_back(last);
    accepted++;
    drive_cycle(1'b1, {last, keep, data});
  endtask

  // All beats out and all credits home
  task automatic wait_drained();
    while (beats_seen < data_q.size() || far_credit() < TOTAL_CREDIT) begin
      drive_cycle(1'b0, '0);
    end
    idle_cycles(4);
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    test_errors0 = total_errors();
  endtask

  task automatic finish_test();
    tests_run++;
    if (total_errors() != test_errors0) begin
      tests_failed++;
      $display("test %s: failed, %0d errors", test_name, total_errors() - test_errors0);
    end else begin
      $display("test %s: ok", test_name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int early;
    int len;
    int sent;
    int credits0;
    int beats0;
    logic online_seen;
    lfsr          = 32'h8aa3c00a;
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    rx_phy        = '0;
    user_tready   = 1'b0;
    tready_mode   = READY_LOW;
    accepted      = 0;
    errors        = 0;
    beat_errors   = 0;
    beats_seen    = 0;
    credits_seen  = 0;
    stb_seen      = 1'b0;
    tests_run     = 0;
    tests_failed  = 0;
    test_name     = "reset";
    repeat (10) @(posedge clk_wr);
    #2;
    reset = 1'b0;

    // Everything quiet before online
    start_test("reset_state");
    idle_cycles(3);
    check_bit("user_tvalid", 1'b0, user_tvalid);
    check_bit("tx_phy is zero", 1'b1, tx_phy == '0);
    check_count("status low half", 16'd0, rx_st_debug_status[15:0]);
    check_count("status high half", 16'd0, rx_st_debug_status[31:16]);
    finish_test();

    // Pushes before rx is online must be dropped
    start_test("online_sequencing");
    delay_x_value = 16'd5;
    delay_y_value = 16'd7;
    delay_z_value = 16'd3;
    tx_online     = 1'b1;
    rx_online     = 1'b1;
    tready_mode   = READY_HIGH;
    user_tready   = 1'b1;
    early         = 0;
    online_seen   = 1'b0;
    while (!online_seen) begin
      @(posedge clk_wr);
      #2;
      rx_phy = '0;
      // Gate value now is the one that samples this push
      if (rx_st_debug_status[25]) begin
        online_seen = 1'b1;
      end else begin
        rx_phy[FLIT_WIDTH-1:0] = FLIT_WIDTH'(rand_bits(DATA_WIDTH));
        rx_phy[PUSH_BIT]       = 1'b1;
        early++;
      end
    end
    idle_cycles(4);
    check_count("dropped", 16'((early > 255) ? 255 : early), {8'd0, rx_st_debug_status[23:16]});
    check_count("beats", 16'd0, 16'(beats_seen));
    check_bit("tx strobe seen", 1'b1, stb_seen);
    check_bit("tx_online_delay", 1'b1, rx_st_debug_status[26]);
    finish_test();

    // Random packets, gaps and back-pressure
    start_test("ordered_stream");
    tready_mode = READY_RANDOM;
    sent        = 0;
    while (sent < STREAM_BEATS) begin
      len = 1 + int'(rand_bits(3));
      for (int i = 0; i < len && sent < STREAM_BEATS; i++) begin
        push_beat((i == len - 1) || (sent == STREAM_BEATS - 1));
        sent++;
        idle_cycles(int'(rand_bits(2)));
      end
    end
    wait_drained();
    check_count("beats", 16'(STREAM_BEATS), 16'(beats_seen));
    finish_test();

    start_test("credit_return");
    check_count("credits vs handshakes", 16'(accepted), 16'(credits_seen));
    check_count("far-side credit", 16'(TOTAL_CREDIT), 16'(far_credit()));
    finish_test();

    // Fill every bank with the output stalled
    start_test("back_pressure");
    tready_mode = READY_LOW;
    idle_cycles(1);
    credits0 = credits_seen;
    beats0   = beats_seen;
    for (int i = 0; i < TOTAL_CREDIT; i++) begin
      push_beat(i == TOTAL_CREDIT - 1);
    end
    idle_cycles(8);
    check_count("credits during stall", 16'(credits0), 16'(credits_seen));
    // First beat of the burst waits on the port
    check_flit("held beat", expected_flit(beats0), {user_tlast, user_tkeep, user_tdata});
    check_bit("overflow", 1'b0, rx_st_debug_status[24]);
    check_bit("user_tvalid held", 1'b1, user_tvalid);
    tready_mode = READY_HIGH;
    wait_drained();
    check_count("far-side credit", 16'(TOTAL_CREDIT), 16'(far_credit()));
    finish_test();

    start_test("accept_counter");
    check_count("accepted", 16'(accepted), rx_st_debug_status[15:0]);
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Run limit from the test lengths
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_wr);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

//--- list.f
verilog/ll_pkg.sv
verilog/axi_st_pkg.sv
verilog/ll_auto_sync.sv
verilog/phy_rx_deframer.sv
verilog/lane_steer.sv
verilog/ll_receive.sv
verilog/stream_merge.sv
verilog/axi_st_d64_slave_top.sv
bench/axi_st_slave_assertions.sv
bench/tb_axi_st_slave.sv

//--- Makefile
TOP = tb_axi_st_slave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
